// File: all.f
common/cdc_link_pkg.sv
source/link_fifo.sv
cdc/cdc_sync.sv
cdc/cdc_2phase_src.sv
cdc/cdc_2phase_dst.sv
source/cdc_link_top.sv
verif/tb_clk_gen.sv
verif/tb_cdc_link.sv

// File: Bender.yml
package:
  name: cdc_link

sources:
  # Design, in compile order
  - common/cdc_link_pkg.sv
  - source/link_fifo.sv
  - cdc/cdc_sync.sv
  - cdc/cdc_2phase_src.sv
  - cdc/cdc_2phase_dst.sv
  - source/cdc_link_top.sv

  # Testbench
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_cdc_link.sv

// File: verif/tb_cdc_link.sv
// Testbench top for the word link, drives both clock domains and checks every delivered word
`default_nettype none

module tb_cdc_link;

  timeunit 1ns;
  timeprecision 100ps;

  import cdc_link_pkg::*;

  localparam logic [31:0] SEED        = 32'd35914;
  localparam int          DRIVE_DELAY = 1;
  localparam int SINGLE_WORDS  = 8;
  localparam int BURST_WORDS   = 64;
  localparam int STALL_WORDS   = 32;
  localparam int MAX_IN_FLIGHT = IN_DEPTH + OUT_DEPTH + 2;
  // The back-pressure test accepts up to the in-flight bound plus the word left pending
  localparam int TOTAL_WORDS   = SINGLE_WORDS + BURST_WORDS + MAX_IN_FLIGHT + 1 + 3 * STALL_WORDS;
  localparam int CYCLE_LIMIT   = 40 * TOTAL_WORDS + 200;
  // Modes of the consumer's ready
  localparam int READY_ON     = 0;
  localparam int READY_OFF    = 1;
  localparam int READY_RANDOM = 2;

  logic       src_clk;
  logic       src_rst_n;
  logic       slow_clk;
  logic       slow_rst_n;
  logic       fast_clk;
  logic       dst_clk;
  logic [1:0] dst_clk_sel;
  logic       dst_rst_n;

  data_t  src_data;
  logic   src_valid;
  logic   src_ready;
  data_t  dst_data;
  logic   dst_valid;
  logic   dst_ready;
  level_t dst_level;

  int sent_cnt      = 0;
  int recv_cnt      = 0;
  int err_cnt       = 0;
  int check_cnt     = 0;
  int test_cnt      = 0;
  int test_err_base = 0;
  int cycle_cnt     = 0;
  int dst_mode;
  logic [31:0] payload_state;
  logic [31:0] src_gap_state;
  logic [31:0] dst_gap_state;

  // The source clock runs at 8 ns and the destination at 8 ns (the source clock), 20 ns or 5 ns
  tb_clk_gen #(.PERIOD_NS(8.0))  u_src_clk  (.clk_o(src_clk),  .rst_n_o(src_rst_n));
  tb_clk_gen #(.PERIOD_NS(20.0)) u_slow_clk (.clk_o(slow_clk), .rst_n_o(slow_rst_n));
  tb_clk_gen #(.PERIOD_NS(5.0))  u_fast_clk (.clk_o(fast_clk), .rst_n_o());

  // The destination clock is only switched while the link is empty
  assign dst_clk   = (dst_clk_sel == 2'd0) ? src_clk : (dst_clk_sel == 2'd1) ? slow_clk : fast_clk;
  // The slow generator holds its reset longest, which covers every destination clock
  assign dst_rst_n = slow_rst_n;

  cdc_link_top dut_i (
    .clk_i       (src_clk),
    .rst_n_i     (src_rst_n),
    .src_data_i  (src_data),
    .src_valid_i (src_valid),
    .src_ready_o (src_ready),
    .dst_clk_i   (dst_clk),
    .dst_rst_n_i (dst_rst_n),
    .dst_data_o  (dst_data),
    .dst_valid_o (dst_valid),
    .dst_ready_i (dst_ready),
    .dst_level_o (dst_level)
  );

  // 32-bit linear congruential step
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // The expected k-th delivered word is regenerated from the seed every time
  function automatic data_t ref_word(input int idx);
    logic [31:0] state;
    state = SEED;
    for (int i = 0; i <= idx; i++) begin
      state = lcg_next(state);
    end
    return state;
  endfunction

  task automatic check_value(input string sig, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt = check_cnt + 1;
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $realtime, sig, expected, actual);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $realtime, what);
    err_cnt = err_cnt + 1;
  endtask

  task automatic end_test(input string name);
    test_cnt = test_cnt + 1;
    $display("Test %0d, %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // Called one drive delay after a source edge, and returns at the same point after the transfer
  task automatic send_word(input int gap);
    logic taken;
    if (gap > 0) begin
      src_valid = 1'b0;
      repeat (gap) @(posedge src_clk);
      #DRIVE_DELAY;
    end
    payload_state = lcg_next(payload_state);
    src_data  = payload_state;
    src_valid = 1'b1;
    do begin
      @(posedge src_clk);
      taken = src_ready;
      #DRIVE_DELAY;
    end while (!taken);
    sent_cnt = sent_cnt + 1;
  endtask

  // Waits until every sent word is out, then makes sure no extra word follows
  task automatic drain();
    src_valid = 1'b0;
    wait (recv_cnt >= sent_cnt);
    repeat (20) @(posedge src_clk);
    #DRIVE_DELAY;
    check_value("delivered count", sent_cnt, recv_cnt);
  endtask

  task automatic stall_run(input logic [1:0] sel, input string name);
    int gap;
    dst_clk_sel = sel;
    repeat (10) @(posedge src_clk);
    #DRIVE_DELAY;
    dst_mode = READY_RANDOM;
    for (int i = 0; i < STALL_WORDS; i++) begin
      src_gap_state = lcg_next(src_gap_state);
      gap = src_gap_state[31] ? int'(src_gap_state[30:29]) : 0;
      send_word(gap);
    end
    drain();
    dst_mode = READY_ON;
    end_test(name);
  endtask

  // Consumer ready is driven one drive delay after each destination edge
  always @(posedge dst_clk) begin
    #DRIVE_DELAY;
    case (dst_mode)
      READY_OFF: dst_ready = 1'b0;
      READY_RANDOM: begin
        dst_gap_state = lcg_next(dst_gap_state);
        dst_ready = (dst_gap_state[31:30] != 2'b00);
      end
      default: dst_ready = 1'b1;
    endcase
  end

  // Every destination transfer is compared with the reference word of the same index
  always @(posedge dst_clk) begin
    if (dst_rst_n) begin
      if (dst_valid && dst_ready) begin
        check_value("dst_data_o", ref_word(recv_cnt), dst_data);
        recv_cnt = recv_cnt + 1;
      end
      if (dst_level > OUT_DEPTH) begin
        $display("FAILED at %0t: dst_level_o expected at most %0d, got %0d",
                 $realtime, OUT_DEPTH, dst_level);
        err_cnt = err_cnt + 1;
      end
    end
  end

  always @(posedge src_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not end within %0d source clock cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    logic taken;
    int   low_run;
    int   guard;
    $timeformat(-9, 1, " ns", 0);
    src_data      = '0;
    src_valid     = 1'b0;
    dst_ready     = 1'b0;
    dst_clk_sel   = 2'd0;
    dst_mode      = READY_ON;
    payload_state = SEED;
    src_gap_state = SEED;
    dst_gap_state = SEED;
    wait (src_rst_n && dst_rst_n);
    @(posedge src_clk);
    #DRIVE_DELAY;

    check_value("dst_valid_o", 32'd0, dst_valid);
    check_value("dst_level_o", 32'd0, dst_level);
    check_value("src_ready_o", 32'd1, src_ready);
    end_test("reset state");

    // Each word has the link to itself before the next one is offered
    for (int i = 0; i < SINGLE_WORDS; i++) begin
      send_word(0);
      src_valid = 1'b0;
      wait (recv_cnt >= sent_cnt);
      @(posedge src_clk);
      #DRIVE_DELAY;
    end
    drain();
    end_test("single words");

    for (int i = 0; i < BURST_WORDS; i++) begin
      send_word(0);
    end
    drain();
    end_test("burst in order");

    // The consumer stalls and the producer keeps offering until the link has filled up
    dst_mode = READY_OFF;
    repeat (3) @(posedge dst_clk);
    @(posedge src_clk);
    #DRIVE_DELAY;
    payload_state = lcg_next(payload_state);
    src_data  = payload_state;
    src_valid = 1'b1;
    low_run   = 0;
    guard     = 0;
    while (low_run < 50 && guard < 200) begin
      @(posedge src_clk);
      taken = src_ready;
      #DRIVE_DELAY;
      guard = guard + 1;
      if (taken) begin
        sent_cnt      = sent_cnt + 1;
        low_run       = 0;
        payload_state = lcg_next(payload_state);
        src_data      = payload_state;
      end else begin
        low_run = low_run + 1;
      end
    end
    if (low_run < 50) begin
      report_error("src_ready_o never stayed low while the consumer was stalled");
    end
    if (sent_cnt - recv_cnt > MAX_IN_FLIGHT) begin
      report_error($sformatf("%0d words were held in the link, more than the limit of %0d",
                             sent_cnt - recv_cnt, MAX_IN_FLIGHT));
    end
    check_value("dst_level_o", OUT_DEPTH, dst_level);
    // Releasing the consumer lets the word still on offer go through first
    dst_mode = READY_ON;
    do begin
      @(posedge src_clk);
      taken = src_ready;
      #DRIVE_DELAY;
    end while (!taken);
    sent_cnt = sent_cnt + 1;
    drain();
    end_test("back-pressure");

    stall_run(2'd0, "random stalls, destination at 8 ns");
    stall_run(2'd1, "random stalls, destination at 20 ns");
    stall_run(2'd2, "random stalls, destination at 5 ns");

    $display("Summary: %0d tests, %0d checks, %0d words sent, %0d delivered, %0d errors",
             test_cnt, check_cnt, sent_cnt, recv_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// Testbench clock and reset source, one instance per clock period that the link test needs
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock that starts low, so the first rising edge falls at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Reset is held for four rising edges and released on a falling edge,
  // well away from the edges that the DUT samples on
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: source/cdc_link_top.sv
// Top level of the word link, joins the source buffer, the toggle crossing and the destination buffer
`default_nettype none

module cdc_link_top (
  // Source clock domain
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  cdc_link_pkg::data_t  src_data_i,
  input  logic                 src_valid_i,
  output logic                 src_ready_o,
  // Destination clock domain
  input  logic                 dst_clk_i,
  input  logic                 dst_rst_n_i,
  output cdc_link_pkg::data_t  dst_data_o,
  output logic                 dst_valid_o,
  input  logic                 dst_ready_i,
  // Fill level of the destination buffer
  output cdc_link_pkg::level_t dst_level_o
);

  import cdc_link_pkg::*;

  // Source buffer read side into the crossing source half
  data_t in_rd_data;
  logic  in_rd_valid;
  logic  in_rd_ready;

  // Wires that cross between the two clock domains
  logic  async_req;
  logic  async_ack;
  data_t async_data;

  // Crossing destination half into the destination buffer write side
  data_t xdst_data;
  logic  xdst_valid;
  logic  xdst_ready;

  // Source-domain buffer absorbs producer bursts while a word is on the crossing.
  // Its fill count has no user at this level
  link_fifo #(
    .DEPTH (IN_DEPTH)
  ) u_in_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_data_i  (src_data_i),
    .wr_valid_i (src_valid_i),
    .wr_ready_o (src_ready_o),
    .rd_data_o  (in_rd_data),
    .rd_valid_o (in_rd_valid),
    .rd_ready_i (in_rd_ready),
    .count_o    ()
  );

  cdc_2phase_src u_cdc_src (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .data_i       (in_rd_data),
    .valid_i      (in_rd_valid),
    .ready_o      (in_rd_ready),
    .async_req_o  (async_req),
    .async_ack_i  (async_ack),
    .async_data_o (async_data)
  );

  cdc_2phase_dst u_cdc_dst (
    .clk_i        (dst_clk_i),
    .rst_n_i      (dst_rst_n_i),
    .data_o       (xdst_data),
    .valid_o      (xdst_valid),
    .ready_i      (xdst_ready),
    .async_req_i  (async_req),
    .async_ack_o  (async_ack),
    .async_data_i (async_data)
  );

  // Destination-domain buffer, its count leaves the top as the fill level
  link_fifo #(
    .DEPTH (OUT_DEPTH)
  ) u_out_fifo (
    .clk_i      (dst_clk_i),
    .rst_n_i    (dst_rst_n_i),
    .wr_data_i  (xdst_data),
    .wr_valid_i (xdst_valid),
    .wr_ready_o (xdst_ready),
    .rd_data_o  (dst_data_o),
    .rd_valid_o (dst_valid_o),
    .rd_ready_i (dst_ready_i),
    .count_o    (dst_level_o)
  );

endmodule

`default_nettype wire

// File: cdc/cdc_2phase_dst.sv
// Destination half of the two-phase crossing, spots a request edge and hands the word onward
`default_nettype none

module cdc_2phase_dst (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Word presented to the destination-domain buffer
  output cdc_link_pkg::data_t data_o,
  output logic                valid_o,
  input  logic                ready_i,
  // Crossing wires from the source half
  input  logic                async_req_i,
  output logic                async_ack_o,
  input  cdc_link_pkg::data_t async_data_i
);

  import cdc_link_pkg::*;

  // Request level after synchronization into this domain
  logic  req_sync;
  // One more cycle of the synchronized request, used to find its edges
  logic  req_dly_q;
  // Acknowledge level, flipped once per word delivered
  logic  ack_q;
  // Word captured off the crossing
  data_t data_q;

  logic  capture;
  logic  accept;

  // Bring the request toggle over from the source domain
  cdc_sync u_req_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .async_i (async_req_i),
    .sync_o  (req_sync)
  );

  // A new word is signalled by an edge on the synchronized request.
  // The async word has been stable since before the request flipped,
  // so sampling it here is safe
  assign capture = (req_sync != req_dly_q) && !valid_o;

  // The delayed request is compared so that valid rises one cycle after the capture,
  // by which point data_q already holds the new word
  assign valid_o = (ack_q != req_dly_q);
  assign accept  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_dly_q <= 1'b0;
    end else begin
      req_dly_q <= req_sync;
    end
  end

  // Flipping the acknowledge closes the word and lets the source half go ready again
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else if (accept) begin
      ack_q <= ~ack_q;
    end
  end

  // Payload capture, the valid logic says when its contents count
  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= async_data_i;
    end
  end

  assign data_o      = data_q;
  assign async_ack_o = ack_q;

endmodule

`default_nettype wire

// File: cdc/cdc_2phase_src.sv
// Source half of the two-phase crossing, takes a word in and announces it by flipping the request
`default_nettype none

module cdc_2phase_src (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Word offered by the source-domain buffer
  input  cdc_link_pkg::data_t data_i,
  input  logic                valid_i,
  output logic                ready_o,
  // Crossing wires towards the destination half
  output logic                async_req_o,
  input  logic                async_ack_i,
  output cdc_link_pkg::data_t async_data_o
);

  import cdc_link_pkg::*;

  // Request level, one flip per word sent
  logic  req_q;
  // Acknowledge level after synchronization into this domain
  logic  ack_sync;
  // Word held on the crossing until the acknowledge comes back
  data_t data_q;

  logic  accept;

  // Bring the acknowledge toggle over from the destination domain
  cdc_sync u_ack_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .async_i (async_ack_i),
    .sync_o  (ack_sync)
  );

  // Equal levels mean the previous word has been taken on the far side
  assign ready_o = (req_q == ack_sync);
  assign accept  = valid_i && ready_o;

  // Each accepted word flips the request once
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= ~req_q;
    end
  end

  // The word changes only on acceptance, so it stays stable while the request is open
  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= data_i;
    end
  end

  assign async_req_o  = req_q;
  assign async_data_o = data_q;

endmodule

`default_nettype wire

// File: cdc/cdc_sync.sv
// Multi-flop synchronizer that brings one toggle level into the receiving clock domain
`default_nettype none

module cdc_sync (
  input  logic clk_i,
  input  logic rst_n_i,
  // Level from the other clock domain, may change at any time
  input  logic async_i,
  // Same level, now safe to use in this domain
  output logic sync_o
);

  import cdc_link_pkg::*;

  // Stage 0 samples the asynchronous level, the last stage is the output
  logic [SYNC_STAGES-1:0] sync_q;

  // All stages clear to zero, which matches the idle level of both toggles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], async_i};
    end
  end

  assign sync_o = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: source/link_fifo.sv
// Single-clock word buffer with valid/ready on both sides and a fill count, used in each domain
`default_nettype none

module link_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Write side, driven by the upstream producer
  input  cdc_link_pkg::data_t          wr_data_i,
  input  logic                         wr_valid_i,
  output logic                         wr_ready_o,
  // Read side, drained by the downstream consumer
  output cdc_link_pkg::data_t          rd_data_o,
  output logic                         rd_valid_o,
  input  logic                         rd_ready_i,
  // Number of words currently stored
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  import cdc_link_pkg::*;

  // Pointer width covers the slot indices 0 to DEPTH-1
  localparam int PTR_W = $clog2(DEPTH);
  // Count width covers 0 to DEPTH inclusive
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage array, written at the write pointer and read at the read pointer
  data_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic wr_en;
  logic rd_en;

  // Handshake completion on each side
  assign wr_en = wr_valid_i && wr_ready_o;
  assign rd_en = rd_valid_o && rd_ready_i;

  // Ready and valid depend on the stored count only, never on the opposite handshake
  assign wr_ready_o = (count_q != CNT_W'(DEPTH));
  assign rd_valid_o = (count_q != '0);

  // The head word is presented straight out of the array
  assign rd_data_o = mem_q[rd_ptr_q];
  assign count_o   = count_q;

  // Payload storage, the count decides which slots hold valid words
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // Pointers advance on their own handshake and wrap after the last slot,
  // so any DEPTH works and not only powers of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (rd_en) begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // A read and a write at the same edge leave the count unchanged
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: common/cdc_link_pkg.sv
// Shared widths, depths and types for the clock-domain crossing link, imported by every RTL block
`default_nettype none

package cdc_link_pkg;

  // Width of one payload word moved from the source to the destination domain
  localparam int DATA_WIDTH = 32;

  // Flops in each toggle synchronizer
  // Two stages is the usual minimum for a single-bit level crossing
  localparam int SYNC_STAGES = 2;

  // Depth of the buffer in the source domain, in words
  localparam int IN_DEPTH = 4;

  // Depth of the buffer in the destination domain, in words
  localparam int OUT_DEPTH = 2;

  // One payload word as it travels through the link
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Fill level of the destination buffer
  // It must hold every value from empty (0) up to OUT_DEPTH inclusive
  typedef logic [$clog2(OUT_DEPTH + 1) - 1:0] level_t;

endpackage

`default_nettype wire
